/* verilog/commit_defines.svh */
`ifndef COMMIT_DEFINES_SVH
`define COMMIT_DEFINES_SVH

// ************************************************************
// Retire width and trace queue sizing
// ************************************************************

`define ISSUE_WIDTH 2 // Slot 1 is the older instruction

`define RFQ_DEPTH_LOG2 6 // 64 trace entries

// Retire pc runs this far ahead of the instruction pc
`define TRACE_PC_OFFSET 32'd8

`endif

/* verilog/core_pkg.sv */
package core_pkg;

    // ************************************************************
    // Datapath words and register addressing
    // ************************************************************

    typedef logic [31:0] word_t;

    typedef logic [4:0] reg_addr_t; // r0 is hardwired to zero

    // One register write as seen by the register file and the trace
    typedef struct packed {
        logic      wen;
        reg_addr_t addr;
        word_t     data;
    } rf_w_t;

endpackage

/* verilog/commit_pkg.sv */
package commit_pkg;

    // Writeback opcodes where wb_none marks an empty slot
    typedef enum logic [3:0] {
        wb_none  = 4'd0,
        wb_alu   = 4'd1,
        wb_link  = 4'd2,
        wb_lb    = 4'd3,
        wb_lbu   = 4'd4,
        wb_lh    = 4'd5,
        wb_lhu   = 4'd6,
        wb_lw    = 4'd7,
        wb_break = 4'd8
    } wb_op_t;

    typedef struct packed {
        wb_op_t              op;
        core_pkg::reg_addr_t dest;
        core_pkg::word_t     alu_result;
        core_pkg::word_t     load_data;  // Raw aligned word from memory
        logic [1:0]          byte_off;
        core_pkg::word_t     pc;         // Retire pc which is the instruction pc plus 8
    } retire_slot_t;

    typedef enum logic {
        wb_run     = 1'b0,
        wb_halted  = 1'b1
    } wb_state_t;

endpackage

/* verilog/wb_result_mux.sv */
`timescale 1ns/100ps

module wb_result_mux
(
    input  commit_pkg::retire_slot_t slot,
    output core_pkg::word_t          result
);

    logic [7:0]  load_byte;
    logic [15:0] load_half;

    // Little-endian lane selection from the aligned load word
    always_comb
    begin
        load_byte = slot.load_data[8*slot.byte_off +: 8];
        if (slot.byte_off[1])
            load_half = slot.load_data[31:16];
        else
            load_half = slot.load_data[15:0];
    end

    always_comb
    begin
        case (slot.op)
            commit_pkg::wb_alu:
                result = slot.alu_result;
            commit_pkg::wb_link:
                result = slot.pc; // Return address
            commit_pkg::wb_lb:
                result = {{24{load_byte[7]}}, load_byte};
            commit_pkg::wb_lbu:
                result = {24'd0, load_byte};
            commit_pkg::wb_lh:
                result = {{16{load_half[15]}}, load_half};
            commit_pkg::wb_lhu:
                result = {16'd0, load_half};
            commit_pkg::wb_lw:
                result = slot.load_data;
            default:
                result = '0; // No register result for none or break
        endcase
    end

endmodule

/* verilog/writeback_control.sv */
`timescale 1ns/100ps

`include "commit_defines.svh"

module writeback_control
(
    input  logic                                       clk,
    input  logic                                       reset,
    input  commit_pkg::retire_slot_t [`ISSUE_WIDTH-1:0] slots,
    output logic [`ISSUE_WIDTH-1:0]                    slot_wen,
    output logic                                       halted
);

    commit_pkg::wb_state_t state;
    commit_pkg::wb_state_t state_next;

    logic [`ISSUE_WIDTH-1:0] is_break;
    logic [`ISSUE_WIDTH-1:0] writes_reg;
    logic [`ISSUE_WIDTH-1:0] older_break;

    // ************************************************************
    // Per-slot decode
    // ************************************************************

    always_comb
    begin
        for (int i = 0; i < `ISSUE_WIDTH; i++)
        begin
            is_break[i]   = (slots[i].op == commit_pkg::wb_break);
            writes_reg[i] = (slots[i].op != commit_pkg::wb_none) &&
                            (slots[i].op != commit_pkg::wb_break) &&
                            (slots[i].dest != '0);
        end
    end

    // A break cancels every younger slot retiring with it
    always_comb
    begin
        logic seen_break;
        seen_break = 1'b0;
        for (int i = `ISSUE_WIDTH-1; i >= 0; i--)
        begin
            older_break[i] = seen_break;
            seen_break     = seen_break | is_break[i];
        end
    end

    always_comb
    begin
        if (state == commit_pkg::wb_run)
            slot_wen = writes_reg & ~older_break;
        else
            slot_wen = '0; // Retirement is frozen once halted
    end

    // ************************************************************
    // Halt state
    // ************************************************************

    always_comb
    begin
        state_next = state;
        if (state == commit_pkg::wb_run && |is_break)
            state_next = commit_pkg::wb_halted;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= commit_pkg::wb_run;
        else
            state <= state_next;
    end

    assign halted = (state == commit_pkg::wb_halted);

endmodule

/* verilog/regfile_2w.sv */
`timescale 1ns/100ps

`include "commit_defines.svh"

module regfile_2w
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  core_pkg::rf_w_t [`ISSUE_WIDTH-1:0]    rfw,
    input  core_pkg::reg_addr_t [1:0]             rd_addr,
    output core_pkg::word_t [1:0]                 rd_data
);

    core_pkg::word_t regs [1:31]; // r0 has no storage

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int r = 1; r < 32; r++)
                regs[r] <= '0;
        end
        else
        begin
            // Walk from the oldest slot down so slot 0 lands last and wins
            for (int i = `ISSUE_WIDTH-1; i >= 0; i--)
            begin
                if (rfw[i].wen && rfw[i].addr != '0)
                    regs[rfw[i].addr] <= rfw[i].data;
            end
        end
    end

    always_comb
    begin
        for (int p = 0; p < 2; p++)
        begin
            if (rd_addr[p] == '0)
                rd_data[p] = '0;
            else
                rd_data[p] = regs[rd_addr[p]];
        end
    end

endmodule

/* verilog/rfwrite_queue.sv */
`timescale 1ns/100ps

`include "commit_defines.svh"

module rfwrite_queue
(
    input  logic                               clk,
    input  logic                               reset,
    input  core_pkg::rf_w_t [`ISSUE_WIDTH-1:0] rfw,
    input  core_pkg::word_t [`ISSUE_WIDTH-1:0] rt_pc,
    output core_pkg::rf_w_t                    rfw_out,
    output core_pkg::word_t                    rt_pc_out
);

    localparam int DEPTH = 1 << `RFQ_DEPTH_LOG2;

    logic [`RFQ_DEPTH_LOG2-1:0] head;
    logic [`RFQ_DEPTH_LOG2-1:0] tail;
    logic [`RFQ_DEPTH_LOG2-1:0] tail_next;
    logic [`RFQ_DEPTH_LOG2-1:0] slot_pos [`ISSUE_WIDTH];
    logic [DEPTH-1:0]           valid;

    core_pkg::rf_w_t rf_mem [DEPTH];
    core_pkg::word_t pc_mem [DEPTH];

    // ************************************************************
    // Tail placement where the oldest slot takes the first free entry
    // ************************************************************

    always_comb
    begin
        tail_next = tail;
        for (int i = `ISSUE_WIDTH-1; i >= 0; i--)
        begin
            slot_pos[i] = tail_next;
            if (rfw[i].wen)
                tail_next = tail_next + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < `ISSUE_WIDTH; i++)
        begin
            if (rfw[i].wen)
            begin
                rf_mem[slot_pos[i]] <= rfw[i];
                pc_mem[slot_pos[i]] <= rt_pc[i] - `TRACE_PC_OFFSET; // Back to instruction pc
            end
        end
    end

    // ************************************************************
    // Pointers, valid bits and the trace output register
    // ************************************************************

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            head      <= '0;
            tail      <= '0;
            valid     <= '0;
            rfw_out   <= '0;
            rt_pc_out <= '0;
        end
        else
        begin
            tail <= tail_next;

            if (valid[head])
            begin
                rfw_out     <= rf_mem[head];
                rt_pc_out   <= pc_mem[head];
                valid[head] <= 1'b0;
                head        <= head + 1'b1;
            end
            else
            begin
                rfw_out   <= '0; // Idle cycle shows an all-zero record
                rt_pc_out <= '0;
            end

            for (int i = 0; i < `ISSUE_WIDTH; i++)
            begin
                if (rfw[i].wen)
                    valid[slot_pos[i]] <= 1'b1;
            end
        end
    end

endmodule

/* verilog/commit_trace_top.sv */
`timescale 1ns/100ps

`include "commit_defines.svh"

module commit_trace_top
(
    input  logic                                        clk,
    input  logic                                        reset,
    input  commit_pkg::retire_slot_t [`ISSUE_WIDTH-1:0] slots,
    input  core_pkg::reg_addr_t [1:0]                   rd_addr,
    output core_pkg::word_t [1:0]                       rd_data,
    output core_pkg::rf_w_t                             trace_w,
    output core_pkg::word_t                             trace_pc,
    output logic                                        halted
);

    logic [`ISSUE_WIDTH-1:0]            slot_wen;
    core_pkg::word_t [`ISSUE_WIDTH-1:0] slot_result;
    core_pkg::rf_w_t [`ISSUE_WIDTH-1:0] slot_rfw;
    core_pkg::word_t [`ISSUE_WIDTH-1:0] slot_pc;

    writeback_control ctrl_i
    (
        .clk      (clk),
        .reset    (reset),
        .slots    (slots),
        .slot_wen (slot_wen),
        .halted   (halted)
    );

    // ************************************************************
    // Per-slot result and write record
    // ************************************************************

    for (genvar i = 0; i < `ISSUE_WIDTH; i++)
    begin : g_slot
        wb_result_mux mux_i
        (
            .slot   (slots[i]),
            .result (slot_result[i])
        );

        assign slot_rfw[i].wen  = slot_wen[i];
        assign slot_rfw[i].addr = slots[i].dest;
        assign slot_rfw[i].data = slot_result[i];
        assign slot_pc[i]       = slots[i].pc;
    end

    regfile_2w regfile_i
    (
        .clk     (clk),
        .reset   (reset),
        .rfw     (slot_rfw),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    rfwrite_queue queue_i
    (
        .clk       (clk),
        .reset     (reset),
        .rfw       (slot_rfw),
        .rt_pc     (slot_pc),
        .rfw_out   (trace_w),
        .rt_pc_out (trace_pc)
    );

endmodule

/* tb/commit_trace_tb.sv */
`timescale 1ns/100ps

`include "commit_defines.svh"

module commit_trace_tb;

    // One clock cycle of stimulus where idle lines expand to several of these
    typedef struct packed {
        logic [127:0]                                name;
        logic                                        is_read;
        commit_pkg::retire_slot_t [`ISSUE_WIDTH-1:0] slots;
        core_pkg::reg_addr_t [1:0]                   rd_addr;
        core_pkg::word_t [1:0]                       rd_expect;
    } step_t;

    typedef struct packed {
        logic [127:0]        name;
        core_pkg::reg_addr_t addr;
        core_pkg::word_t     data;
        core_pkg::word_t     pc;
    } trace_rec_t;

    logic                                        clk;
    logic                                        reset;
    commit_pkg::retire_slot_t [`ISSUE_WIDTH-1:0] slots;
    core_pkg::reg_addr_t [1:0]                   rd_addr;
    core_pkg::word_t [1:0]                       rd_data;
    core_pkg::rf_w_t                             trace_w;
    core_pkg::word_t                             trace_pc;
    logic                                        halted;

    step_t           steps [$];
    trace_rec_t      expected_trace [$];
    core_pkg::word_t model_regs [32];
    bit              model_halted;
    bit              stimulus_loaded;
    logic [127:0]    cur_name;
    logic [127:0]    sampled_name;
    int              mismatches;
    int              other_errors;

    commit_trace_top dut_i
    (
        .clk      (clk),
        .reset    (reset),
        .slots    (slots),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .trace_w  (trace_w),
        .trace_pc (trace_pc),
        .halted   (halted)
    );

    always #5 clk = ~clk;

    // ************************************************************
    // Reference rules for the writeback path
    // ************************************************************

    function automatic commit_pkg::wb_op_t op_from_name(input logic [127:0] s, output bit known);
        known = 1'b1;
        if (s == "none") return commit_pkg::wb_none;
        if (s == "alu") return commit_pkg::wb_alu;
        if (s == "link") return commit_pkg::wb_link;
        if (s == "lb") return commit_pkg::wb_lb;
        if (s == "lbu") return commit_pkg::wb_lbu;
        if (s == "lh") return commit_pkg::wb_lh;
        if (s == "lhu") return commit_pkg::wb_lhu;
        if (s == "lw") return commit_pkg::wb_lw;
        if (s == "break") return commit_pkg::wb_break;
        known = 1'b0;
        return commit_pkg::wb_none;
    endfunction

    function automatic bit writes_register(input commit_pkg::retire_slot_t s);
        return s.op != commit_pkg::wb_none && s.op != commit_pkg::wb_break && s.dest != 5'd0;
    endfunction

    function automatic core_pkg::word_t expected_result(input commit_pkg::retire_slot_t s);
        logic [7:0]  b;
        logic [15:0] h;
        case (s.byte_off) // Little-endian byte lanes
            2'd0: b = s.load_data[7:0];
            2'd1: b = s.load_data[15:8];
            2'd2: b = s.load_data[23:16];
            default: b = s.load_data[31:24];
        endcase
        h = s.byte_off[1] ? s.load_data[31:16] : s.load_data[15:0];
        case (s.op)
            commit_pkg::wb_alu: return s.alu_result;
            commit_pkg::wb_link: return s.pc;
            commit_pkg::wb_lb: return {{24{b[7]}}, b};
            commit_pkg::wb_lbu: return {24'd0, b};
            commit_pkg::wb_lh: return {{16{h[15]}}, h};
            commit_pkg::wb_lhu: return {16'd0, h};
            commit_pkg::wb_lw: return s.load_data;
            default: return 32'd0;
        endcase
    endfunction

    task automatic load_stimulus(output bit ok);
        int           fd;
        int           code;
        int           ch;
        int           n;
        int           d1;
        int           off1;
        int           d0;
        int           off0;
        logic [127:0] tok;
        logic [127:0] name;
        logic [127:0] op1;
        logic [127:0] op0;
        logic [31:0]  alu1;
        logic [31:0]  ld1;
        logic [31:0]  pc1;
        logic [31:0]  alu0;
        logic [31:0]  ld0;
        logic [31:0]  pc0;
        bit           known1;
        bit           known0;
        step_t        st;
        ok = 1'b1;
        fd = $fopen("tb/commit_input.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open the stimulus file tb/commit_input.txt");
            ok = 1'b0;
        end
        else
        begin
            code = $fscanf(fd, " %s", tok);
            while (code == 1 && ok)
            begin
                st = '0;
                if (tok == "#")
                begin
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1)
                        ch = $fgetc(fd);
                end
                else if (tok == "cyc")
                begin
                    code = $fscanf(fd, " %s %s %d %h %h %d %h %s %d %h %h %d %h", name,
                                   op1, d1, alu1, ld1, off1, pc1, op0, d0, alu0, ld0, off0, pc0);
                    st.name = name;
                    st.slots[1] = {op_from_name(op1, known1), d1[4:0], alu1, ld1, off1[1:0], pc1};
                    st.slots[0] = {op_from_name(op0, known0), d0[4:0], alu0, ld0, off0[1:0], pc0};
                    ok = (code == 13) && known1 && known0;
                    steps.push_back(st);
                end
                else if (tok == "idle")
                begin
                    code = $fscanf(fd, " %s %d", name, n);
                    st.name = name;
                    ok = (code == 2);
                    repeat (n) steps.push_back(st);
                end
                else if (tok == "read")
                begin
                    code = $fscanf(fd, " %s %d %d %h %h", name, d1, d0, alu1, alu0);
                    st.name = name;
                    st.is_read = 1'b1;
                    st.rd_addr = {d0[4:0], d1[4:0]};
                    st.rd_expect = {alu0, alu1};
                    ok = (code == 5);
                    steps.push_back(st);
                end
                else
                    ok = 1'b0;
                if (!ok)
                    $display("Stimulus file has a malformed line near %0s", tok);
                else
                    code = $fscanf(fd, " %s", tok);
            end
            $fclose(fd);
        end
    endtask

    task automatic check_reads(input step_t st);
        for (int p = 0; p < 2; p++)
        begin
            assert (rd_data[p] == st.rd_expect[p]) else
            begin
                mismatches++;
                $display("MISMATCH %0s r%0d expected %h actual %h", st.name, st.rd_addr[p],
                         st.rd_expect[p], rd_data[p]);
            end
            assert (rd_data[p] == model_regs[st.rd_addr[p]]) else
            begin
                mismatches++;
                $display("MISMATCH %0s r%0d model expected %h actual %h", st.name, st.rd_addr[p],
                         model_regs[st.rd_addr[p]], rd_data[p]);
            end
        end
    endtask

    // ************************************************************
    // Models update on the sampling edge and checks run at the falling edge
    // ************************************************************

    always @(posedge clk)
    begin
        trace_rec_t rec;
        logic [1:0] en;
        sampled_name = cur_name;
        if (!reset && !model_halted)
        begin
            en[1] = writes_register(slots[1]);
            en[0] = writes_register(slots[0]) && slots[1].op != commit_pkg::wb_break;
            for (int i = 1; i >= 0; i--) // Older slot is traced first
            begin
                if (en[i])
                begin
                    rec.name = cur_name;
                    rec.addr = slots[i].dest;
                    rec.data = expected_result(slots[i]);
                    rec.pc = slots[i].pc - `TRACE_PC_OFFSET;
                    expected_trace.push_back(rec);
                    model_regs[slots[i].dest] = rec.data; // Slot 0 lands last and wins
                end
            end
            if (slots[1].op == commit_pkg::wb_break || slots[0].op == commit_pkg::wb_break)
                model_halted = 1'b1;
        end
    end

    always @(negedge clk)
    begin
        trace_rec_t exp_rec;
        if (!reset)
        begin
            assert (halted == model_halted) else
            begin
                mismatches++;
                $display("MISMATCH %0s halted expected %0b actual %0b", sampled_name,
                         model_halted, halted);
            end
            if (trace_w.wen)
            begin
                assert (expected_trace.size() != 0) else
                begin
                    other_errors++;
                    $display("Trace record for r%0d appeared with no write pending", trace_w.addr);
                end
                if (expected_trace.size() != 0)
                begin
                    exp_rec = expected_trace.pop_front();
                    assert (trace_w.addr == exp_rec.addr && trace_w.data == exp_rec.data) else
                    begin
                        mismatches++;
                        $display("MISMATCH %0s trace expected r%0d=%h actual r%0d=%h", exp_rec.name,
                                 exp_rec.addr, exp_rec.data, trace_w.addr, trace_w.data);
                    end
                    assert (trace_pc == exp_rec.pc) else
                    begin
                        mismatches++;
                        $display("MISMATCH %0s trace pc expected %h actual %h", exp_rec.name,
                                 exp_rec.pc, trace_pc);
                    end
                end
            end
            else
            begin
                assert (trace_w == '0 && trace_pc == '0) else
                begin
                    mismatches++;
                    $display("MISMATCH %0s idle trace expected 0 actual %h pc %h", sampled_name,
                             trace_w, trace_pc);
                end
            end
        end
    end

    initial
    begin
        int limit_ns;
        wait (stimulus_loaded);
        limit_ns = (steps.size() + 80) * 10;
        #(limit_ns);
        $display("Watchdog expired before the stimulus finished");
        $display("Simulation failed");
        $finish;
    end

    initial
    begin
        bit load_ok;
        clk = 1'b0;
        reset = 1'b1;
        slots = '0;
        rd_addr = '0;
        cur_name = "reset";
        sampled_name = "reset";
        for (int r = 0; r < 32; r++)
            model_regs[r] = '0;
        load_stimulus(load_ok);
        if (!load_ok)
        begin
            $display("Stimulus could not be loaded");
            $display("Simulation failed");
            $finish;
        end
        else
        begin
            stimulus_loaded = 1'b1;
            repeat (2) @(posedge clk);
            #1;
            reset = 1'b0;
            foreach (steps[i])
            begin
                @(posedge clk);
                #1;
                cur_name = steps[i].name;
                slots = steps[i].slots;
                rd_addr = steps[i].rd_addr;
                if (steps[i].is_read)
                begin
                    @(negedge clk);
                    check_reads(steps[i]);
                end
            end
            @(posedge clk);
            #2;
            assert (expected_trace.size() == 0) else
            begin
                other_errors++;
                $display("%0d expected trace records never appeared", expected_trace.size());
            end
            $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
            if (mismatches == 0 && other_errors == 0)
                $display("Simulation passed");
            else
                $display("Simulation failed");
            $finish;
        end
    end

endmodule

/* tb/commit_input.txt */
# cyc name op1 dest1 alu1 load1 off1 pc1 op0 dest0 alu0 load0 off0 pc0 (slot 1 older, dest/off decimal, rest hex)
# idle name cycles | read name addr0 addr1 expect0 expect1 (addr decimal, expect hex)
cyc alu_single none 0 0 0 0 0 alu 1 11111111 0 0 00400008
idle alu_single 3
cyc alu_dual alu 2 22222222 0 0 0040000c alu 3 33333333 0 0 00400010
idle alu_dual 3
cyc lb_0_3 lb 4 0 80ff7f01 0 00400020 lb 5 0 80ff7f01 3 00400024
cyc lbu_2_1 lbu 6 0 80ff7f01 2 00400028 lbu 7 0 80ff7f01 1 0040002c
cyc lb_1_2 lb 8 0 80ff7f01 1 00400030 lb 9 0 80ff7f01 2 00400034
cyc lbu_3_0 lbu 10 0 80ff7f01 3 00400038 lbu 11 0 80ff7f01 0 0040003c
cyc lh_0_2 lh 12 0 80ff7f01 0 00400040 lh 13 0 80ff7f01 2 00400044
cyc lhu_0_2 lhu 14 0 80ff7f01 0 00400048 lhu 15 0 80ff7f01 2 0040004c
cyc lw_link lw 16 0 80ff7f01 0 00400050 link 18 0 0 0 00400054
idle loads 16
cyc link_r0 link 31 0 0 0 00400060 alu 0 dead0000 0 0 00400064
cyc r0_load lw 0 0 12345678 0 00400068 none 0 0 0 0 0
idle link_r0 4
cyc clash alu 20 aaaa0001 0 0 00400070 alu 20 bbbb0002 0 0 00400074
idle clash 4
cyc burst_0 alu 21 b0000021 0 0 00400080 alu 26 b0000026 0 0 00400084
cyc burst_1 alu 22 b0000022 0 0 00400088 alu 27 b0000027 0 0 0040008c
cyc burst_2 alu 23 b0000023 0 0 00400090 alu 28 b0000028 0 0 00400094
cyc burst_3 alu 24 b0000024 0 0 00400098 alu 29 b0000029 0 0 0040009c
cyc burst_4 alu 25 b0000025 0 0 004000a0 alu 30 b0000030 0 0 004000a4
idle burst 14
read alu_regs 1 2 11111111 22222222
read alu_clash 3 20 33333333 bbbb0002
read loads_a 4 5 00000001 ffffff80
read loads_b 6 7 000000ff 0000007f
read loads_c 8 9 0000007f ffffffff
read loads_d 10 11 00000080 00000001
read loads_e 12 13 00007f01 ffff80ff
read loads_f 14 15 00007f01 000080ff
read lw_link 16 18 80ff7f01 00400054
read link_r0 0 31 00000000 00400060
read burst_a 21 30 b0000021 b0000030
read burst_b 23 27 b0000023 b0000027
cyc brk break 0 0 0 0 004000b0 alu 19 19191919 0 0 004000b4
cyc after_brk alu 1 deadbeef 0 0 004000b8 alu 2 cafef00d 0 0 004000bc
idle after_brk 6
read brk_cancel 19 1 00000000 11111111
read brk_frozen 2 25 22222222 b0000025

/* all.f */
+incdir+verilog
verilog/core_pkg.sv
verilog/commit_pkg.sv
verilog/wb_result_mux.sv
verilog/writeback_control.sv
verilog/regfile_2w.sv
verilog/rfwrite_queue.sv
verilog/commit_trace_top.sv
tb/commit_trace_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module commit_trace_tb
	./obj_dir/Vcommit_trace_tb | tee /dev/stderr | grep -q "Simulation passed"

clean:
	rm -rf obj_dir
